/* common/armCtrlPkg.sv */
`default_nettype none

package armCtrlPkg;

  // Condition field encodings
  localparam logic [3:0] condEq = 4'b0000;
  localparam logic [3:0] condNe = 4'b0001;
  localparam logic [3:0] condCs = 4'b0010;
  localparam logic [3:0] condCc = 4'b0011;
  localparam logic [3:0] condMi = 4'b0100;
  localparam logic [3:0] condPl = 4'b0101;
  localparam logic [3:0] condVs = 4'b0110;
  localparam logic [3:0] condVc = 4'b0111;
  localparam logic [3:0] condHi = 4'b1000;
  localparam logic [3:0] condLs = 4'b1001;
  localparam logic [3:0] condGe = 4'b1010;
  localparam logic [3:0] condLt = 4'b1011;
  localparam logic [3:0] condGt = 4'b1100;
  localparam logic [3:0] condLe = 4'b1101;
  localparam logic [3:0] condAl = 4'b1110;

  // Instruction class, bits 27:26
  localparam logic [1:0] opDp     = 2'b00;
  localparam logic [1:0] opMem    = 2'b01;
  localparam logic [1:0] opBranch = 2'b10;

  // Data-processing commands, bits 24:21
  localparam logic [3:0] cmdAnd = 4'b0000;
  localparam logic [3:0] cmdEor = 4'b0001;
  localparam logic [3:0] cmdSub = 4'b0010;
  localparam logic [3:0] cmdRsb = 4'b0011;
  localparam logic [3:0] cmdAdd = 4'b0100;
  localparam logic [3:0] cmdAdc = 4'b0101;
  localparam logic [3:0] cmdSbc = 4'b0110;
  localparam logic [3:0] cmdRsc = 4'b0111;
  localparam logic [3:0] cmdTst = 4'b1000;
  localparam logic [3:0] cmdTeq = 4'b1001;
  localparam logic [3:0] cmdCmp = 4'b1010;
  localparam logic [3:0] cmdCmn = 4'b1011;
  localparam logic [3:0] cmdOrr = 4'b1100;
  localparam logic [3:0] cmdMov = 4'b1101;
  localparam logic [3:0] cmdBic = 4'b1110;
  localparam logic [3:0] cmdMvn = 4'b1111;

  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        imm;
    logic [3:0]  cmd;
    logic        s;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;  // Rm in bits 3:0 for the register form
  } dpFmt;

  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        imm;
    logic        p;
    logic        u;
    logic        b;
    logic        w;
    logic        l;  // Set for LDR
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;
  } memFmt;

  typedef union packed {
    dpFmt  dp;
    memFmt mem;
  } instrWord;

  typedef struct packed {
    logic neg;
    logic zero;
    logic carry;
    logic overflow;
  } flagsT;

  typedef struct packed {
    logic [1:0] flagWrite;  // NZ in bit 1, CV in bit 0
    logic       branch;
    logic       memWrite;
    logic       regWrite;
    logic       pcSrc;
    logic       memtoReg;
    logic       aluSrc;
    logic [3:0] aluControl;
    logic [3:0] cond;
  } decodeCtrl;

  typedef struct packed {
    logic memWrite;
    logic memtoReg;
    logic regWrite;
    logic pcSrc;
  } memCtrl;

  typedef struct packed {
    logic memtoReg;
    logic regWrite;
    logic pcSrc;
  } wbCtrl;

  typedef enum logic [1:0] {
    none    = 2'b00,
    fromWb  = 2'b01,
    fromMem = 2'b10
  } fwdSel;

endpackage

`default_nettype wire

/* controller/instrDecoder.sv */
`default_nettype none
`timescale 1ns/1ps

module instrDecoder (
  input  wire armCtrlPkg::instrWord instrD,
  output logic [1:0]                regSrcD,
  output logic [1:0]                immSrcD,
  output logic                      pcSrcD,
  output armCtrlPkg::decodeCtrl     ctrlD
);

  logic isCompare;
  logic isArith;

  // TST, TEQ, CMP and CMN only set flags
  assign isCompare = (instrD.dp.cmd[3:2] == 2'b10);

  assign isArith = instrD.dp.cmd inside {
    armCtrlPkg::cmdAdd, armCtrlPkg::cmdSub, armCtrlPkg::cmdRsb, armCtrlPkg::cmdAdc,
    armCtrlPkg::cmdSbc, armCtrlPkg::cmdRsc, armCtrlPkg::cmdCmp, armCtrlPkg::cmdCmn
  };

  always_comb begin
    ctrlD = '0;
    regSrcD = 2'b00;
    immSrcD = 2'b00;
    ctrlD.cond = instrD.dp.cond;
    ctrlD.aluControl = armCtrlPkg::cmdAdd;  // Address and target adds
    case (instrD.dp.op)
      armCtrlPkg::opDp: begin
        ctrlD.aluSrc = instrD.dp.imm;
        ctrlD.regWrite = ~isCompare;
        ctrlD.aluControl = instrD.dp.cmd;
        ctrlD.flagWrite = {instrD.dp.s, instrD.dp.s & isArith};
      end
      armCtrlPkg::opMem: begin
        immSrcD = 2'b01;  // 12-bit offset
        ctrlD.aluSrc = 1'b1;
        if (instrD.mem.l) begin
          ctrlD.memtoReg = 1'b1;
          ctrlD.regWrite = 1'b1;
        end else begin
          regSrcD = 2'b10;  // STR reads Rd as store data
          ctrlD.memWrite = 1'b1;
        end
      end
      armCtrlPkg::opBranch: begin
        regSrcD = 2'b01;  // Base is the PC
        immSrcD = 2'b10;  // 24-bit word offset
        ctrlD.aluSrc = 1'b1;
        ctrlD.branch = 1'b1;
      end
      default: begin
        ctrlD = '0;
      end
    endcase
    // Any write to R15 redirects fetch
    ctrlD.pcSrc = (ctrlD.regWrite && instrD.dp.rd == 4'd15) || ctrlD.branch;
  end

  assign pcSrcD = ctrlD.pcSrc;

  // Op 2'b11 covers coprocessor and SWI, none of which this core runs
  always_comb begin
    assert (instrD.dp.op !== 2'b11)
      else $error("Unimplemented op field %b in Decode", instrD.dp.op);
  end

endmodule

`default_nettype wire

/* controller/condUnit.sv */
`default_nettype none
`timescale 1ns/1ps

module condUnit (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic [3:0]        cond,
  input  wire logic [1:0]        flagWrite,
  input  wire armCtrlPkg::flagsT aluFlags,
  output logic                   condEx,
  output armCtrlPkg::flagsT      flags
);

  armCtrlPkg::flagsT flagsNext;
  logic ge;

  assign ge = (flags.neg == flags.overflow);  // Signed greater or equal

  always_comb begin
    case (cond)
      armCtrlPkg::condEq: condEx = flags.zero;
      armCtrlPkg::condNe: condEx = ~flags.zero;
      armCtrlPkg::condCs: condEx = flags.carry;
      armCtrlPkg::condCc: condEx = ~flags.carry;
      armCtrlPkg::condMi: condEx = flags.neg;
      armCtrlPkg::condPl: condEx = ~flags.neg;
      armCtrlPkg::condVs: condEx = flags.overflow;
      armCtrlPkg::condVc: condEx = ~flags.overflow;
      armCtrlPkg::condHi: condEx = flags.carry & ~flags.zero;
      armCtrlPkg::condLs: condEx = ~(flags.carry & ~flags.zero);
      armCtrlPkg::condGe: condEx = ge;
      armCtrlPkg::condLt: condEx = ~ge;
      armCtrlPkg::condGt: condEx = ~flags.zero & ge;
      armCtrlPkg::condLe: condEx = ~(~flags.zero & ge);
      armCtrlPkg::condAl: condEx = 1'b1;
      default:            condEx = 1'b0;  // Reserved encoding never executes
    endcase
  end

  // NZ and CV load independently
  always_comb begin
    flagsNext = flags;
    if (flagWrite[1] && condEx) begin
      flagsNext.neg = aluFlags.neg;
      flagsNext.zero = aluFlags.zero;
    end
    if (flagWrite[0] && condEx) begin
      flagsNext.carry = aluFlags.carry;
      flagsNext.overflow = aluFlags.overflow;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else begin
      flags <= flagsNext;  // Loads at the edge that ends Execute
    end
  end

endmodule

`default_nettype wire

/* controller/ctrlPipeline.sv */
`default_nettype none
`timescale 1ns/1ps

module ctrlPipeline (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire armCtrlPkg::decodeCtrl ctrlD,
  input  wire logic                  flushE,
  input  wire armCtrlPkg::flagsT     aluFlagsE,
  output logic                       aluSrcE,
  output logic [3:0]                 aluControlE,
  output logic                       branchTakenE,
  output logic                       carryInE,
  output logic                       memtoRegE,
  output logic                       pcSrcE,
  output logic                       memWriteM,
  output logic                       regWriteM,
  output logic                       pcSrcM,
  output logic                       memtoRegW,
  output logic                       regWriteW,
  output logic                       pcSrcW
);

  armCtrlPkg::decodeCtrl ctrlE;
  armCtrlPkg::memCtrl    memE;
  armCtrlPkg::memCtrl    memM;
  armCtrlPkg::wbCtrl     wbW;
  armCtrlPkg::flagsT     flagsE;
  logic                  condExE;

  // Execute register, a flush turns the slot into a bubble
  always_ff @(posedge clk) begin
    if (rst || flushE) begin
      ctrlE <= '0;
    end else begin
      ctrlE <= ctrlD;
    end
  end

  condUnit condCheck (
    .clk       (clk),
    .rst       (rst),
    .cond      (ctrlE.cond),
    .flagWrite (ctrlE.flagWrite),
    .aluFlags  (aluFlagsE),
    .condEx    (condExE),
    .flags     (flagsE)
  );

  assign aluSrcE = ctrlE.aluSrc;
  assign aluControlE = ctrlE.aluControl;
  assign memtoRegE = ctrlE.memtoReg;
  assign pcSrcE = ctrlE.pcSrc;  // Ungated, used for fetch hazard
  assign branchTakenE = ctrlE.branch & condExE;
  assign carryInE = flagsE.carry;  // For ADC, SBC and RSC

  // Side effects only leave Execute when the condition passes
  assign memE.memWrite = ctrlE.memWrite & condExE;
  assign memE.memtoReg = ctrlE.memtoReg;
  assign memE.regWrite = ctrlE.regWrite & condExE;
  assign memE.pcSrc = ctrlE.pcSrc & condExE;

  always_ff @(posedge clk) begin
    if (rst) begin
      memM <= '0;
    end else begin
      memM <= memE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wbW <= '0;
    end else begin
      wbW.memtoReg <= memM.memtoReg;
      wbW.regWrite <= memM.regWrite;
      wbW.pcSrc <= memM.pcSrc;
    end
  end

  assign memWriteM = memM.memWrite;
  assign regWriteM = memM.regWrite;
  assign pcSrcM = memM.pcSrc;
  assign memtoRegW = wbW.memtoReg;
  assign regWriteW = wbW.regWrite;
  assign pcSrcW = wbW.pcSrc;

  // A store never also loads into the register file
  assert property (@(posedge clk) disable iff (rst)
    !(memWriteM && regWriteM && memM.memtoReg))
    else $error("Store and load both active in Memory");

endmodule

`default_nettype wire

/* logic/hazardUnit.sv */
`default_nettype none
`timescale 1ns/1ps

module hazardUnit (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire armCtrlPkg::instrWord instrD,
  input  wire logic                 memtoRegE,
  input  wire logic                 regWriteM,
  input  wire logic                 regWriteW,
  input  wire logic                 pcSrcD,
  input  wire logic                 pcSrcE,
  input  wire logic                 pcSrcM,
  input  wire logic                 branchTakenE,
  output logic                      stallF,
  output logic                      stallD,
  output logic                      flushD,
  output logic                      flushE,
  output armCtrlPkg::fwdSel         forwardAE,
  output armCtrlPkg::fwdSel         forwardBE
);

  logic [3:0] src1D, src2D;
  logic       use1D, use2D;
  logic [3:0] src1E, src2E;
  logic       use1E, use2E;
  logic [3:0] wa3E, wa3M, wa3W;
  logic       ldrStallD;
  logic       pcWrPendingF;

  // Second source is Rm for DP register form, Rd for STR
  assign src1D = instrD.dp.rn;
  assign src2D = (instrD.dp.op == armCtrlPkg::opMem) ? instrD.mem.rd : instrD.dp.operand2[3:0];

  // R15 reads come from the PC, never from forwarding
  assign use1D = (instrD.dp.op == armCtrlPkg::opDp || instrD.dp.op == armCtrlPkg::opMem)
                 && src1D != 4'd15;
  assign use2D = ((instrD.dp.op == armCtrlPkg::opDp && !instrD.dp.imm)
                 || (instrD.dp.op == armCtrlPkg::opMem && !instrD.mem.l))
                 && src2D != 4'd15;

  always_ff @(posedge clk) begin
    if (rst) begin
      src1E <= '0;
      src2E <= '0;
      use1E <= 1'b0;
      use2E <= 1'b0;
      wa3E <= '0;
      wa3M <= '0;
      wa3W <= '0;
    end else begin
      src1E <= src1D;
      src2E <= src2D;
      use1E <= use1D & ~flushE;  // Bubble reads nothing
      use2E <= use2D & ~flushE;
      wa3E <= instrD.dp.rd;
      wa3M <= wa3E;
      wa3W <= wa3M;
    end
  end

  function automatic armCtrlPkg::fwdSel pickFwd(input logic [3:0] src, input logic used);
    if (used && regWriteM && src == wa3M) begin
      return armCtrlPkg::fromMem;  // Newest value wins
    end else if (used && regWriteW && src == wa3W) begin
      return armCtrlPkg::fromWb;
    end
    return armCtrlPkg::none;
  endfunction

  assign forwardAE = pickFwd(src1E, use1E);
  assign forwardBE = pickFwd(src2E, use2E);

  assign ldrStallD = memtoRegE && ((use1D && src1D == wa3E) || (use2D && src2D == wa3E));
  assign pcWrPendingF = pcSrcD | pcSrcE | pcSrcM;

  assign stallF = ldrStallD | pcWrPendingF;
  assign stallD = ldrStallD;
  // A stalled Decode keeps its instruction
  assign flushD = ~ldrStallD & (pcWrPendingF | branchTakenE);
  assign flushE = ldrStallD | branchTakenE;

  // Load moves on to Memory, so the stall lasts one cycle only
  assert property (@(posedge clk) disable iff (rst) stallD |=> !stallD)
    else $error("Load-use stall lasted more than one cycle");

endmodule

`default_nettype wire

/* controller/armControl.sv */
`default_nettype none
`timescale 1ns/1ps

module armControl (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire armCtrlPkg::instrWord instrD,
  input  wire armCtrlPkg::flagsT    aluFlagsE,
  output logic [1:0]                regSrcD,
  output logic [1:0]                immSrcD,
  output logic                      aluSrcE,
  output logic [3:0]                aluControlE,
  output logic                      branchTakenE,
  output logic                      carryInE,
  output logic                      memWriteM,
  output logic                      memtoRegW,
  output logic                      regWriteW,
  output logic                      pcSrcW,
  output logic                      stallF,
  output logic                      stallD,
  output logic                      flushD,
  output armCtrlPkg::fwdSel         forwardAE,
  output armCtrlPkg::fwdSel         forwardBE
);

  armCtrlPkg::decodeCtrl ctrlD;
  logic                  pcSrcD;
  logic                  flushE;
  logic                  memtoRegE;
  logic                  pcSrcE;
  logic                  pcSrcM;
  logic                  regWriteM;

  instrDecoder decoder (
    .instrD  (instrD),
    .regSrcD (regSrcD),
    .immSrcD (immSrcD),
    .pcSrcD  (pcSrcD),
    .ctrlD   (ctrlD)
  );

  ctrlPipeline pipeline (
    .clk          (clk),
    .rst          (rst),
    .ctrlD        (ctrlD),
    .flushE       (flushE),
    .aluFlagsE    (aluFlagsE),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .branchTakenE (branchTakenE),
    .carryInE     (carryInE),
    .memtoRegE    (memtoRegE),
    .pcSrcE       (pcSrcE),
    .memWriteM    (memWriteM),
    .regWriteM    (regWriteM),
    .pcSrcM       (pcSrcM),
    .memtoRegW    (memtoRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW)
  );

  hazardUnit hazards (
    .clk          (clk),
    .rst          (rst),
    .instrD       (instrD),
    .memtoRegE    (memtoRegE),
    .regWriteM    (regWriteM),
    .regWriteW    (regWriteW),
    .pcSrcD       (pcSrcD),
    .pcSrcE       (pcSrcE),
    .pcSrcM       (pcSrcM),
    .branchTakenE (branchTakenE),
    .stallF       (stallF),
    .stallD       (stallD),
    .flushD       (flushD),
    .flushE       (flushE),
    .forwardAE    (forwardAE),
    .forwardBE    (forwardBE)
  );

endmodule

`default_nettype wire

/* testbench/armControlTb.sv */
`default_nettype none
`timescale 1ns/1ps

module armControlTb;

  localparam int maxCases = 64;
  localparam int randomRounds = 32;
  localparam int roundCycles = 5;
  localparam logic [31:0] addsWord = 32'hE092_1003;  // ADDS r1, r2, r3
  localparam logic [31:0] nopWord = 32'hE100_0000;   // TST r0, r0 without S

  logic                 clk;
  logic                 rst;
  armCtrlPkg::instrWord instrD;
  armCtrlPkg::flagsT    aluFlagsE;
  logic [1:0]           regSrcD;
  logic [1:0]           immSrcD;
  logic                 aluSrcE;
  logic [3:0]           aluControlE;
  logic                 branchTakenE;
  logic                 carryInE;
  logic                 memWriteM;
  logic                 memtoRegW;
  logic                 regWriteW;
  logic                 pcSrcW;
  logic                 stallF;
  logic                 stallD;
  logic                 flushD;
  armCtrlPkg::fwdSel    forwardAE;
  armCtrlPkg::fwdSel    forwardBE;

  logic [31:0] caseMem [0:4*maxCases];  // Count word, then four words per case
  logic [31:0] lfsr;
  int          numCases;
  int          limitCycles;
  int          errors;
  int          checks;

  armControl uut (
    .clk          (clk),
    .rst          (rst),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .branchTakenE (branchTakenE),
    .carryInE     (carryInE),
    .memWriteM    (memWriteM),
    .memtoRegW    (memtoRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .stallF       (stallF),
    .stallD       (stallD),
    .flushD       (flushD),
    .forwardAE    (forwardAE),
    .forwardBE    (forwardBE)
  );

  always #20 clk = ~clk;

  task automatic checkValue(input logic [31:0] got, input logic [31:0] want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, want);
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic randomBit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return b;
  endfunction

  function automatic logic [3:0] randomField();
    logic [3:0] v;
    v = '0;
    for (int k = 0; k < 4; k++) begin
      v = {v[2:0], randomBit()};
    end
    return v;
  endfunction

  // ARM condition table, odd codes invert the even ones
  function automatic logic condHolds(input logic [3:0] cond, input armCtrlPkg::flagsT f);
    logic base;
    case (cond[3:1])
      3'b000:  base = f.zero;
      3'b001:  base = f.carry;
      3'b010:  base = f.neg;
      3'b011:  base = f.overflow;
      3'b100:  base = f.carry && !f.zero;
      3'b101:  base = (f.neg == f.overflow);
      3'b110:  base = !f.zero && (f.neg == f.overflow);
      default: base = 1'b1;  // AL
    endcase
    return base ^ cond[0];
  endfunction

  // Same nibble layout as the third column of the cases file
  function automatic logic [31:0] frontOutputs();
    return {2'b00, regSrcD, 2'b00, immSrcD, 3'b000, aluSrcE, aluControlE, 3'b000, branchTakenE,
            3'b000, carryInE, 3'b000, memWriteM, 3'b000, memtoRegW};
  endfunction

  function automatic logic [31:0] backOutputs();
    return {3'b000, regWriteW, 3'b000, pcSrcW, 3'b000, stallF, 3'b000, stallD, 3'b000, flushD,
            2'b00, forwardAE, 2'b00, forwardBE, 4'h0};
  endfunction

  task automatic stepCycle(input logic [31:0] instr, input logic [3:0] flags);
    @(negedge clk);
    rst = 1'b0;
    instrD = instr;
    aluFlagsE = flags;
    #18;  // Just ahead of the rising edge
  endtask

  // ADDS sets NZCV, a conditional B reads them, a conditional STR follows the B
  task automatic runRandomRound(input int round);
    logic [3:0]        branchCond;
    logic [3:0]        storeCond;
    armCtrlPkg::flagsT flagBits;
    logic              taken;
    logic              stored;
    branchCond = randomField();
    if (branchCond == 4'hF) branchCond = armCtrlPkg::condAl;
    storeCond = randomField();
    if (storeCond == 4'hF) storeCond = armCtrlPkg::condAl;
    flagBits = randomField();
    taken = condHolds(branchCond, flagBits);
    stored = !taken && condHolds(storeCond, flagBits);  // A taken branch flushes the STR
    stepCycle(addsWord, 4'h0);
    stepCycle({branchCond, 28'hA00_0010}, flagBits);
    stepCycle({storeCond, 28'h585_4000}, 4'h0);
    checkValue(branchTakenE, taken,
               $sformatf("round %0d branchTakenE cond %h flags %b", round, branchCond, flagBits));
    checkValue(carryInE, flagBits.carry, $sformatf("round %0d carryInE", round));
    stepCycle(nopWord, 4'h0);
    stepCycle(nopWord, 4'h0);
    checkValue(pcSrcW, taken, $sformatf("round %0d pcSrcW cond %h", round, branchCond));
    checkValue(memWriteM, stored,
               $sformatf("round %0d memWriteM store cond %h flags %b", round, storeCond, flagBits));
    checkValue(regWriteW, 1'b0, $sformatf("round %0d regWriteW after branch", round));
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    instrD = '0;
    aluFlagsE = '0;
    errors = 0;
    checks = 0;
    lfsr = 32'h9dab_d6af;
    caseMem[0] = '0;
    $readmemh("testbench/ctrlCases.mem", caseMem);
    numCases = caseMem[0];
    if (numCases < 1 || numCases > maxCases) begin
      $display("Case file testbench/ctrlCases.mem is missing or holds a bad case count");
      errors++;
      numCases = 0;
    end
    limitCycles = 5 + numCases + randomRounds * roundCycles + 20;
    repeat (5) @(posedge clk);
    for (int row = 0; row < numCases; row++) begin
      stepCycle(caseMem[1 + 4*row], caseMem[2 + 4*row][3:0]);
      checkValue(frontOutputs(), caseMem[3 + 4*row],
                 $sformatf("row %0d decode and execute outputs", row));
      checkValue(backOutputs(), caseMem[4 + 4*row],
                 $sformatf("row %0d writeback and hazard outputs", row));
    end
    for (int round = 0; round < randomRounds; round++) begin
      runRandomRound(round);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #1;
    #(limitCycles * 40);
    $display("Watchdog expired, the run went past %0d clock cycles", limitCycles);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/ctrlCases.mem */
// Columns: instrD, aluFlagsE (NZCV), expected front word, expected back word
// Front nibbles: regSrcD immSrcD aluSrcE aluControlE branchTakenE carryInE memWriteM memtoRegW
// Back nibbles: regWriteW pcSrcW stallF stallD flushD forwardAE forwardBE 0
00000016                             // 22 cases
E2821005 0 00000000 00000000         // ADD r1, r2, #5
E0413004 0 00140000 00000000         // SUB r3, r1, r4
E1815003 0 00020000 00000200         // ORR r5, r1, r3
E1000000 0 000C0000 10000120         // NOP
E5916008 0 01080000 10000000         // LDR r6, [r1, #8]
E0867002 0 00140000 10110000         // ADD r7, r6, r2 stalls on the load
E0867002 0 00000000 00000000         // Held in Decode, bubble in Execute
E5817004 0 21040001 10000100         // STR r7, [r1, #4]
E2528001 0 00140000 00000020         // SUBS r8, r2, #1
E2129003 3 00120010 10000000         // ANDS r9, r2, #3
E1000000 C 00100100 00000000         // ANDS loads NZ only
1252A001 0 00080100 10000000         // SUBSNE r10, r2, #1
E1000000 5 00120100 10000000         // SUBSNE fails, flags kept
0A000010 0 12080100 00101000         // BEQ taken
E282B001 0 00141100 00101000         // ADD r11 flushed by the branch
E1000000 0 00000100 00101000
E1000000 0 00080100 01000000         // Branch reaches Writeback
E1A0F002 0 00080100 00101000         // MOV pc, r2
E1000000 0 000D0100 00101000
E1000000 0 00080100 00101000
E1000000 0 00080100 11000000         // PC write in Writeback
E1000000 0 00080100 00000000

/* sources.f */
common/armCtrlPkg.sv
controller/instrDecoder.sv
controller/condUnit.sv
controller/ctrlPipeline.sv
logic/hazardUnit.sv
controller/armControl.sv
testbench/armControlTb.sv

/* Makefile */
# Verilator build and run for the ARM pipeline control testbench

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module armControlTb -o simv

run: build
	./obj_dir/simv | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module armControl

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
